// ==== dv/legCoreModel.svh ====
`ifndef LEG_CORE_MODEL_SVH
`define LEG_CORE_MODEL_SVH

// architectural state as software sees it
logic [63:0] mReg [32];
logic [63:0] mMem [16];
logic [63:0] mPc;
logic [3:0] mFlags;

// expected retire report of the last applied instruction
logic expWrite;
logic expHasData;
logic [4:0] expReg;
logic [63:0] expData;

task automatic resetModel();
	for (int i = 0; i < 32; i++) begin
		mReg[i] = '0;
	end
	for (int i = 0; i < 16; i++) begin
		mMem[i] = '0;
	end
	mPc = '0;
	mFlags = '0;
endtask

// condition pairs share a base test, odd codes invert it, 111x always holds
function automatic logic condHolds(input logic [3:0] cc, input logic [3:0] f);
	logic base;
	case (cc[3:1])
		3'd0: base = f[FLAG_Z];
		3'd1: base = f[FLAG_C];
		3'd2: base = f[FLAG_N];
		3'd3: base = f[FLAG_V];
		3'd4: base = f[FLAG_C] && !f[FLAG_Z];
		3'd5: base = (f[FLAG_N] == f[FLAG_V]);
		3'd6: base = (f[FLAG_N] == f[FLAG_V]) && !f[FLAG_Z];
		default: base = 1'b1;
	endcase
	if (cc[0] && (cc[3:1] != 3'd7)) begin
		base = !base;
	end
	return base;
endfunction

task automatic applyInstr(input logic [31:0] word);
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] res;
	logic [63:0] bOff;
	logic [63:0] cbOff;
	logic [63:0] addr;
	logic [63:0] nextPc;
	logic [64:0] wide;
	a = mReg[word[9:5]];
	b = mReg[word[20:16]];
	bOff = {{36{word[25]}}, word[25:0], 2'b00};
	cbOff = {{43{word[23]}}, word[23:5], 2'b00};
	addr = a + {{55{word[20]}}, word[20:12]};
	nextPc = mPc + 64'd4;
	expHasData = 1'b0;
	expReg = word[4:0];
	expData = '0;
	if (word[31:26] == OP_B) begin
		nextPc = mPc + bOff;
	end
	else if (word[31:24] == OP_BCOND) begin
		if (condHolds(word[3:0], mFlags)) begin
			nextPc = mPc + cbOff;
		end
	end
	else if (word[31:26] == OP_BL) begin
		nextPc = mPc + bOff;
		expHasData = 1'b1;
		expReg = LINK_REG;
		expData = mPc + 64'd4;
	end
	else if (word[31:21] == OP_BR) begin
		nextPc = a;
	end
	else if (word[31:24] == OP_CBZ) begin
		if (mReg[word[4:0]] == 64'd0) begin
			nextPc = mPc + cbOff;
		end
	end
	else if (word[31:22] == OP_ADDI) begin
		expHasData = 1'b1;
		expData = a + {52'd0, word[21:10]};
	end
	else if ((word[31:21] == OP_ADDS) || (word[31:21] == OP_SUBS)) begin
		if (word[31:21] == OP_ADDS) begin
			wide = {1'b0, a} + {1'b0, b};
			res = wide[63:0];
			mFlags[FLAG_C] = wide[64];
			mFlags[FLAG_V] = (a[63] == b[63]) && (res[63] != a[63]);
		end
		else begin
			res = a - b;
			// no borrow when a is at least b
			mFlags[FLAG_C] = (a >= b);
			mFlags[FLAG_V] = (a[63] != b[63]) && (res[63] != a[63]);
		end
		mFlags[FLAG_N] = res[63];
		mFlags[FLAG_Z] = (res == 64'd0);
		expHasData = 1'b1;
		expData = res;
	end
	else if (word[31:21] == OP_LDUR) begin
		expHasData = 1'b1;
		expData = mMem[addr[6:3]];
	end
	else if (word[31:21] == OP_STUR) begin
		mMem[addr[6:3]] = mReg[word[4:0]];
	end
	// X31 is never written
	expWrite = expHasData && (expReg != ZERO_REG);
	if (expWrite) begin
		mReg[expReg] = expData;
	end
	mPc = nextPc;
endtask

`endif

// ==== dv/legCoreTb.sv ====
module legCoreTb import legIsaPkg::*, legCtrlPkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int MAX_GAP = 3;
	localparam int N_ARITH = 80;
	localparam int N_STORE = 32;
	localparam int N_COND = 48;
	localparam int N_UNCOND = 30;
	localparam int N_UNKNOWN = 12;
	// every instruction issued over all tests
	localparam int TOTAL_INSTR = 32 + N_ARITH + N_STORE + MEM_DEPTH + 2 * N_COND +
		N_UNCOND + N_UNCOND / 3 + N_UNKNOWN;
	localparam int WATCHDOG_TIME = TOTAL_INSTR * (MAX_GAP + 2) * 10 * 2;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instrValid;
	logic [63:0] pc;
	logic [3:0] flags;
	logic retired;
	logic retiredWrite;
	logic [4:0] retiredReg;
	logic [63:0] retiredData;

	string curTest;
	int checkCount;
	int errorCount;
	int testChecks;
	int testErrors;

	`include "legCoreModel.svh"

	legCore legCore_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.pc(pc),
		.flags(flags),
		.retired(retired),
		.retiredWrite(retiredWrite),
		.retiredReg(retiredReg),
		.retiredData(retiredData)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic checkValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: test %s, %s expected %h actual %h", curTest, what, expected, actual);
		end
	endtask

	task automatic beginTest(input string name);
		curTest = name;
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		$display("test %s finished: %0d checks, %0d errors", curTest,
			checkCount - testChecks, errorCount - testErrors);
	endtask

	// instruction word builders
	function automatic logic [31:0] rWord(input logic [10:0] op, input logic [4:0] rm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] iWord(input logic [9:0] op, input logic [11:0] imm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, imm, rn, rd};
	endfunction

	function automatic logic [31:0] dWord(input logic [10:0] op, input logic [8:0] addr9,
		input logic [4:0] rn, input logic [4:0] rt);
		return {op, addr9, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] bWord(input logic [5:0] op, input logic [25:0] imm);
		return {op, imm};
	endfunction

	function automatic logic [31:0] cbWord(input logic [7:0] op, input logic [18:0] imm,
		input logic [4:0] rt);
		return {op, imm, rt};
	endfunction

	function automatic logic [4:0] randReg();
		return 5'($urandom_range(31, 0));
	endfunction

	// no strobe, so nothing may move
	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			checkValue("idle retired", 64'd0, retired);
			checkValue("idle pc", mPc, pc);
			checkValue("idle flags", mFlags, flags);
		end
	endtask

	// strobe on a falling edge, commit at the rising edge, check on the next falling edge
	task automatic runInstr(input logic [31:0] word);
		instr = word;
		instrValid = 1'b1;
		applyInstr(word);
		@(negedge clk);
		instrValid = 1'b0;
		checkValue("retired", 64'd1, retired);
		checkValue("pc", mPc, pc);
		checkValue("flags", mFlags, flags);
		checkValue("retiredWrite", expWrite, retiredWrite);
		if (expHasData) begin
			checkValue("retiredReg", expReg, retiredReg);
			checkValue("retiredData", expData, retiredData);
		end
		if ($urandom_range(3, 0) == 0) begin
			idleCycles($urandom_range(MAX_GAP, 1));
		end
	endtask

	task automatic resetTest();
		beginTest("reset");
		checkValue("pc after reset", 64'd0, pc);
		checkValue("flags after reset", 64'd0, flags);
		checkValue("retired after reset", 64'd0, retired);
		for (int r = 0; r < 32; r++) begin
			runInstr(iWord(OP_ADDI, 12'd0, 5'(r), 5'(r)));
		end
		endTest();
	endtask

	task automatic arithTest();
		int kind;
		beginTest("arith");
		for (int i = 0; i < N_ARITH; i++) begin
			// half ADDI, the rest split between ADDS and SUBS
			kind = $urandom_range(3, 0);
			if (kind < 2) begin
				runInstr(iWord(OP_ADDI, 12'($urandom), randReg(), randReg()));
			end
			else if (kind == 2) begin
				runInstr(rWord(OP_ADDS, randReg(), randReg(), randReg()));
			end
			else begin
				runInstr(rWord(OP_SUBS, randReg(), randReg(), randReg()));
			end
		end
		endTest();
	endtask

	task automatic memoryTest();
		int idx;
		beginTest("memory");
		// X31 base keeps every address inside the memory
		for (int i = 0; i < N_STORE; i++) begin
			idx = $urandom_range(MEM_DEPTH - 1, 0);
			runInstr(dWord(OP_STUR, 9'(idx * 8), ZERO_REG, randReg()));
		end
		for (int i = 0; i < MEM_DEPTH; i++) begin
			runInstr(dWord(OP_LDUR, 9'(i * 8), ZERO_REG, randReg()));
		end
		endTest();
	endtask

	task automatic condTest();
		logic [4:0] rt;
		beginTest("conditional");
		for (int i = 0; i < N_COND; i++) begin
			// fresh flags before every branch
			runInstr(rWord(OP_SUBS, randReg(), randReg(), randReg()));
			if (i % 3 == 2) begin
				// X31 half the time so both outcomes show up
				rt = ($urandom_range(1, 0) == 1) ? ZERO_REG : randReg();
				runInstr(cbWord(OP_CBZ, 19'($urandom), rt));
			end
			else begin
				runInstr(cbWord(OP_BCOND, 19'($urandom), {1'b0, 4'(i % 16)}));
			end
		end
		endTest();
	endtask

	task automatic uncondTest();
		beginTest("unconditional");
		for (int i = 0; i < N_UNCOND; i++) begin
			if (i % 3 == 0) begin
				runInstr(bWord(OP_B, 26'($urandom)));
			end
			else if (i % 3 == 1) begin
				runInstr(bWord(OP_BL, 26'($urandom)));
				// read the link register back
				runInstr(iWord(OP_ADDI, 12'd0, LINK_REG, randReg()));
			end
			else begin
				runInstr(rWord(OP_BR, ZERO_REG, randReg(), 5'd0));
			end
		end
		endTest();
	endtask

	task automatic idleTest();
		beginTest("idle");
		for (int i = 0; i < N_UNKNOWN; i++) begin
			idleCycles($urandom_range(MAX_GAP, 1));
			// top six bits clear match no opcode
			runInstr({6'b000000, 26'($urandom)});
		end
		endTest();
	endtask

	initial begin
		void'($urandom(32'hbcbe));
		rst = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		checkCount = 0;
		errorCount = 0;
		resetModel();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;
		resetTest();
		arithTest();
		memoryTest();
		condTest();
		uncondTest();
		idleTest();
		$display("summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== rtl/cpuControl.sv ====
module cpuControl import legIsaPkg::*, legCtrlPkg::*; (
	input instrWord_u instr,
	output logic uncondBr,
	output logic branch,
	output logic branchReg,
	output logic branchLink,
	output logic reg2Loc,
	output logic aluSrc,
	output logic immSel,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic setFlags,
	output logic [1:0] aluOp
);

	always_comb begin
		// everything inactive unless an opcode claims it
		uncondBr = 1'b0;
		branch = 1'b0;
		branchReg = 1'b0;
		branchLink = 1'b0;
		reg2Loc = 1'b0;
		aluSrc = 1'b0;
		immSel = 1'b0;
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		setFlags = 1'b0;
		aluOp = ALU_ADD;

		if (instr.bFmt.opcode == OP_B) begin
			uncondBr = 1'b1;
		end
		else if (instr.cbFmt.opcode == OP_BCOND) begin
			// taken or not decided by the stored flags
			branch = 1'b1;
		end
		else if (instr.bFmt.opcode == OP_BL) begin
			uncondBr = 1'b1;
			branch = 1'b1;
			branchLink = 1'b1;
			regWrite = 1'b1;
		end
		else if (instr.rFmt.opcode == OP_BR) begin
			branchReg = 1'b1;
		end
		else if (instr.cbFmt.opcode == OP_CBZ) begin
			// Rt passed through the ALU for the zero test
			branch = 1'b1;
			reg2Loc = 1'b1;
			aluOp = ALU_PASSB;
		end
		else if (instr.iFmt.opcode == OP_ADDI) begin
			aluSrc = 1'b1;
			immSel = 1'b1;
			regWrite = 1'b1;
		end
		else if (instr.rFmt.opcode == OP_ADDS) begin
			regWrite = 1'b1;
			setFlags = 1'b1;
		end
		else if (instr.dFmt.opcode == OP_LDUR) begin
			aluSrc = 1'b1;
			regWrite = 1'b1;
			memToReg = 1'b1;
		end
		else if (instr.dFmt.opcode == OP_STUR) begin
			aluSrc = 1'b1;
			memWrite = 1'b1;
		end
		else if (instr.rFmt.opcode == OP_SUBS) begin
			regWrite = 1'b1;
			setFlags = 1'b1;
			aluOp = ALU_SUB;
		end
	end

	// a store never also writes a register
	noWriteClash: assert final (!(memWrite && regWrite))
		else $error("memWrite and regWrite both active");

	// register branch and immediate branch are exclusive
	oneBranchKind: assert final ($onehot0({branchReg, uncondBr}))
		else $error("branchReg and uncondBr both active");

endmodule

// ==== rtl/execUnit.sv ====
module execUnit import legIsaPkg::*, legCtrlPkg::*; (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic uncondBr,
	input logic branch,
	input logic branchReg,
	input logic branchLink,
	input logic reg2Loc,
	input logic aluSrc,
	input logic immSel,
	input logic regWrite,
	input logic memToReg,
	input logic memWrite,
	input logic setFlags,
	input logic [1:0] aluOp,
	input logic [DATA_W-1:0] rnVal,
	input logic [DATA_W-1:0] rmVal,
	input logic [DATA_W-1:0] rtVal,
	input logic [DATA_W-1:0] immI,
	input logic [DATA_W-1:0] immD,
	input logic [DATA_W-1:0] brOffB,
	input logic [DATA_W-1:0] brOffCb,
	input logic [3:0] condCode,
	input logic [REG_AW-1:0] destReg,
	output logic wbEn,
	output logic [REG_AW-1:0] wbReg,
	output logic [DATA_W-1:0] wbData,
	output logic [DATA_W-1:0] pc,
	output logic [3:0] flags,
	output logic retired,
	output logic retiredWrite,
	output logic [REG_AW-1:0] retiredReg,
	output logic [DATA_W-1:0] retiredData
);

	logic [DATA_W-1:0] dataMem [MEM_DEPTH];

	logic [DATA_W-1:0] opB;
	logic [DATA_W-1:0] bAdj;
	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] aluResult;
	logic carryOut;
	logic subOp;
	logic [3:0] aluFlags;
	logic condTrue;
	logic taken;
	logic [MEM_AW-1:0] memIdx;
	logic [DATA_W-1:0] memData;
	logic [DATA_W-1:0] pcPlus4;
	logic [DATA_W-1:0] nextPc;

	// operand B, Rt wins over the immediates
	assign opB = reg2Loc ? rtVal : (aluSrc ? (immSel ? immI : immD) : rmVal);

	// subtract as A + ~B + 1
	assign subOp = (aluOp == ALU_SUB);
	assign bAdj = subOp ? ~opB : opB;
	assign {carryOut, sum} = {1'b0, rnVal} + {1'b0, bAdj} + {{DATA_W{1'b0}}, subOp};

	always_comb begin
		case (aluOp)
			ALU_ADD, ALU_SUB: aluResult = sum;
			ALU_PASSB: aluResult = opB;
			default: aluResult = sum;
		endcase
	end

	assign aluFlags[FLAG_N] = aluResult[DATA_W-1];
	assign aluFlags[FLAG_Z] = (aluResult == '0);
	assign aluFlags[FLAG_C] = carryOut;
	assign aluFlags[FLAG_V] = (rnVal[DATA_W-1] == bAdj[DATA_W-1]) &&
		(sum[DATA_W-1] != rnVal[DATA_W-1]);

	// B.cond tests the flags already stored, not this cycle's ALU flags
	always_comb begin
		case (condCode)
			COND_EQ: condTrue = flags[FLAG_Z];
			COND_NE: condTrue = !flags[FLAG_Z];
			COND_HS: condTrue = flags[FLAG_C];
			COND_LO: condTrue = !flags[FLAG_C];
			COND_MI: condTrue = flags[FLAG_N];
			COND_PL: condTrue = !flags[FLAG_N];
			COND_VS: condTrue = flags[FLAG_V];
			COND_VC: condTrue = !flags[FLAG_V];
			COND_HI: condTrue = flags[FLAG_C] && !flags[FLAG_Z];
			COND_LS: condTrue = !(flags[FLAG_C] && !flags[FLAG_Z]);
			COND_GE: condTrue = (flags[FLAG_N] == flags[FLAG_V]);
			COND_LT: condTrue = (flags[FLAG_N] != flags[FLAG_V]);
			COND_GT: condTrue = !flags[FLAG_Z] && (flags[FLAG_N] == flags[FLAG_V]);
			COND_LE: condTrue = !(!flags[FLAG_Z] && (flags[FLAG_N] == flags[FLAG_V]));
			COND_AL, COND_NV: condTrue = 1'b1;
			default: condTrue = 1'b1;
		endcase
	end

	// reg2Loc marks CBZ among the conditional branches
	assign taken = uncondBr || (branch && (reg2Loc ? aluFlags[FLAG_Z] : condTrue));

	assign pcPlus4 = pc + DATA_W'(4);
	assign nextPc = branchReg ? rnVal :
		(taken ? pc + (uncondBr ? brOffB : brOffCb) : pcPlus4);

	// doubleword index from the effective address
	assign memIdx = aluResult[MEM_AW+2:3];
	assign memData = dataMem[memIdx];

	assign wbReg = branchLink ? LINK_REG : destReg;
	assign wbData = memToReg ? memData : (branchLink ? pcPlus4 : aluResult);
	assign wbEn = instrValid && regWrite && (wbReg != ZERO_REG);

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				dataMem[i] <= '0;
			end
		end
		else if (instrValid && memWrite) begin
			dataMem[memIdx] <= rtVal;
		end
	end

	// architectural state and retire report
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= '0;
			flags <= '0;
			retired <= 1'b0;
			retiredWrite <= 1'b0;
		end
		else begin
			retired <= instrValid;
			retiredWrite <= wbEn;
			if (instrValid) begin
				pc <= nextPc;
			end
			if (instrValid && setFlags) begin
				flags <= aluFlags;
			end
		end
	end

	// payload of the report
	always_ff @(posedge clk) begin
		if (instrValid) begin
			retiredReg <= wbReg;
			retiredData <= wbData;
		end
	end

	retireFollowsStrobe: assert property (@(posedge clk) disable iff (!rst)
		retired |-> $past(instrValid))
		else $error("retired without a preceding instruction strobe");

endmodule

// ==== rtl/legCore.sv ====
module legCore import legIsaPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord_u instr,
	input logic instrValid,
	output logic [DATA_W-1:0] pc,
	output logic [3:0] flags,
	output logic retired,
	output logic retiredWrite,
	output logic [REG_AW-1:0] retiredReg,
	output logic [DATA_W-1:0] retiredData
);

	// control levels
	logic uncondBr;
	logic branch;
	logic branchReg;
	logic branchLink;
	logic reg2Loc;
	logic aluSrc;
	logic immSel;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	logic setFlags;
	logic [1:0] aluOp;

	// operands and fields
	logic [DATA_W-1:0] rnVal;
	logic [DATA_W-1:0] rmVal;
	logic [DATA_W-1:0] rtVal;
	logic [DATA_W-1:0] immI;
	logic [DATA_W-1:0] immD;
	logic [DATA_W-1:0] brOffB;
	logic [DATA_W-1:0] brOffCb;
	logic [3:0] condCode;
	logic [REG_AW-1:0] destReg;

	// write-back loop
	logic wbEn;
	logic [REG_AW-1:0] wbReg;
	logic [DATA_W-1:0] wbData;

	cpuControl cpuControl_i (
		.instr(instr),
		.uncondBr(uncondBr),
		.branch(branch),
		.branchReg(branchReg),
		.branchLink(branchLink),
		.reg2Loc(reg2Loc),
		.aluSrc(aluSrc),
		.immSel(immSel),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.setFlags(setFlags),
		.aluOp(aluOp)
	);

	operandFetch operandFetch_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.rnVal(rnVal),
		.rmVal(rmVal),
		.rtVal(rtVal),
		.immI(immI),
		.immD(immD),
		.brOffB(brOffB),
		.brOffCb(brOffCb),
		.condCode(condCode),
		.destReg(destReg)
	);

	execUnit execUnit_i (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.uncondBr(uncondBr),
		.branch(branch),
		.branchReg(branchReg),
		.branchLink(branchLink),
		.reg2Loc(reg2Loc),
		.aluSrc(aluSrc),
		.immSel(immSel),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.setFlags(setFlags),
		.aluOp(aluOp),
		.rnVal(rnVal),
		.rmVal(rmVal),
		.rtVal(rtVal),
		.immI(immI),
		.immD(immD),
		.brOffB(brOffB),
		.brOffCb(brOffCb),
		.condCode(condCode),
		.destReg(destReg),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.pc(pc),
		.flags(flags),
		.retired(retired),
		.retiredWrite(retiredWrite),
		.retiredReg(retiredReg),
		.retiredData(retiredData)
	);

endmodule

// ==== rtl/legCtrlPkg.sv ====
package legCtrlPkg;

	// ALU operation select
	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_SUB = 2'd1;
	localparam logic [1:0] ALU_PASSB = 2'd2;

	// bit positions in the NZCV flag word
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	// data memory, indexed by doubleword
	localparam int MEM_DEPTH = 16;
	localparam int MEM_AW = 4;

endpackage

// ==== rtl/legIsaPkg.sv ====
package legIsaPkg;

	// register file geometry
	localparam int DATA_W = 64;
	localparam int REG_AW = 5;
	localparam logic [REG_AW-1:0] LINK_REG = 5'd30;
	localparam logic [REG_AW-1:0] ZERO_REG = 5'd31;

	// opcode match values, matched on the leading bits of the word
	localparam logic [5:0] OP_B = 6'b000101;
	localparam logic [5:0] OP_BL = 6'b100101;
	localparam logic [7:0] OP_BCOND = 8'b01010100;
	localparam logic [7:0] OP_CBZ = 8'b10110100;
	localparam logic [9:0] OP_ADDI = 10'b1001000100;
	localparam logic [10:0] OP_BR = 11'b11010110000;
	localparam logic [10:0] OP_ADDS = 11'b10101011000;
	localparam logic [10:0] OP_SUBS = 11'b11101011000;
	localparam logic [10:0] OP_LDUR = 11'b11111000010;
	localparam logic [10:0] OP_STUR = 11'b11111000000;

	// B.cond condition numbers
	localparam logic [3:0] COND_EQ = 4'h0;
	localparam logic [3:0] COND_NE = 4'h1;
	localparam logic [3:0] COND_HS = 4'h2;
	localparam logic [3:0] COND_LO = 4'h3;
	localparam logic [3:0] COND_MI = 4'h4;
	localparam logic [3:0] COND_PL = 4'h5;
	localparam logic [3:0] COND_VS = 4'h6;
	localparam logic [3:0] COND_VC = 4'h7;
	localparam logic [3:0] COND_HI = 4'h8;
	localparam logic [3:0] COND_LS = 4'h9;
	localparam logic [3:0] COND_GE = 4'ha;
	localparam logic [3:0] COND_LT = 4'hb;
	localparam logic [3:0] COND_GT = 4'hc;
	localparam logic [3:0] COND_LE = 4'hd;
	localparam logic [3:0] COND_AL = 4'he;
	localparam logic [3:0] COND_NV = 4'hf;

	// one instruction word, five ways of reading it
	typedef union packed {
		struct packed {
			logic [10:0] opcode;
			logic [REG_AW-1:0] rm;
			logic [5:0] shamt;
			logic [REG_AW-1:0] rn;
			logic [REG_AW-1:0] rd;
		} rFmt;
		struct packed {
			logic [9:0] opcode;
			logic [11:0] imm12;
			logic [REG_AW-1:0] rn;
			logic [REG_AW-1:0] rd;
		} iFmt;
		struct packed {
			logic [10:0] opcode;
			logic [8:0] addr9;
			logic [1:0] op2;
			logic [REG_AW-1:0] rn;
			logic [REG_AW-1:0] rt;
		} dFmt;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] imm26;
		} bFmt;
		struct packed {
			logic [7:0] opcode;
			logic [18:0] imm19;
			// condition code in the low bits for B.cond
			logic [REG_AW-1:0] rt;
		} cbFmt;
	} instrWord_u;

endpackage

// ==== rtl/operandFetch.sv ====
module operandFetch import legIsaPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord_u instr,
	input logic wbEn,
	input logic [REG_AW-1:0] wbReg,
	input logic [DATA_W-1:0] wbData,
	output logic [DATA_W-1:0] rnVal,
	output logic [DATA_W-1:0] rmVal,
	output logic [DATA_W-1:0] rtVal,
	output logic [DATA_W-1:0] immI,
	output logic [DATA_W-1:0] immD,
	output logic [DATA_W-1:0] brOffB,
	output logic [DATA_W-1:0] brOffCb,
	output logic [3:0] condCode,
	output logic [REG_AW-1:0] destReg
);

	// X0 to X30 only, X31 has no storage
	logic [DATA_W-1:0] regFile [0:ZERO_REG-1];

	logic [REG_AW-1:0] rnAddr;
	logic [REG_AW-1:0] rmAddr;
	logic [REG_AW-1:0] rtAddr;

	// Rn and Rt sit at the same bits in every format that has them
	assign rnAddr = instr.rFmt.rn;
	assign rmAddr = instr.rFmt.rm;
	assign rtAddr = instr.dFmt.rt;

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < ZERO_REG; i++) begin
				regFile[i] <= '0;
			end
		end
		else if (wbEn) begin
			regFile[wbReg] <= wbData;
		end
	end

	// X31 reads as zero
	assign rnVal = (rnAddr == ZERO_REG) ? '0 : regFile[rnAddr];
	assign rmVal = (rmAddr == ZERO_REG) ? '0 : regFile[rmAddr];
	assign rtVal = (rtAddr == ZERO_REG) ? '0 : regFile[rtAddr];

	// immediates
	assign immI = {{(DATA_W-12){1'b0}}, instr.iFmt.imm12};
	assign immD = {{(DATA_W-9){instr.dFmt.addr9[8]}}, instr.dFmt.addr9};

	// branch offsets in words, turned into byte offsets
	assign brOffB = {{(DATA_W-28){instr.bFmt.imm26[25]}}, instr.bFmt.imm26, 2'b00};
	assign brOffCb = {{(DATA_W-21){instr.cbFmt.imm19[18]}}, instr.cbFmt.imm19, 2'b00};

	assign condCode = instr.cbFmt.rt[3:0];
	assign destReg = instr.rFmt.rd;

	// the execute unit filters X31 out before it gets here
	noZeroRegWrite: assert property (@(posedge clk) disable iff (!rst)
		wbEn |-> (wbReg != ZERO_REG))
		else $error("register write aimed at X31");

endmodule

// ==== sources.f ====
+incdir+dv
rtl/legIsaPkg.sv
rtl/legCtrlPkg.sv
rtl/cpuControl.sv
rtl/operandFetch.sv
rtl/execUnit.sv
rtl/legCore.sv
dv/legCoreTb.sv
